// File: filelist.f
+incdir+include
hw/rv32i_types_pkg.sv
hw/operand_sel_pkg.sv
hw/regfile.sv
hw/control_rom.sv
hw/hazard_unit.sv
hw/instruction_decode.sv
sim/tb_instruction_decode.sv

// File: hw/control_rom.sv
`timescale 1ns/1ps

module control_rom
    import rv32i_types_pkg::*;
    import operand_sel_pkg::*;
(
    input  rv32i_instr_u      instr,
    output rv32i_control_word ctrl,
    output alumux1_sel_t      alumux1_sel,
    output alumux2_sel_t      alumux2_sel,
    output cmpmux_sel_t       cmpmux_sel
);

    logic   known;
    logic   alt_op;
    logic   shift_ok;
    logic   is_slt;
    alu_ops arith_op;

    // bit 30 selects sub and sra, read through whichever view fits the format
    always_comb
    begin
        if (instr.r.opcode == op_reg)
            alt_op = instr.r.funct7[5];
        else
            alt_op = instr.i.imm12[10];

        // upper immediate bits around the shamt must be clear
        shift_ok = (instr.i.imm12[11] == 1'b0) && (instr.i.imm12[9:5] == '0);
        is_slt = (instr.r.funct3[2:1] == 2'b01);

        case (instr.r.funct3)
            3'b000: arith_op = (alt_op && instr.r.opcode == op_reg) ? alu_sub : alu_add;
            3'b001: arith_op = alu_sll;
            3'b100: arith_op = alu_xor;
            3'b101: arith_op = alt_op ? alu_sra : alu_srl;
            3'b110: arith_op = alu_or;
            3'b111: arith_op = alu_and;
            // slt and sltu resolve in the comparator
            default: arith_op = alu_add;
        endcase
    end

    always_comb
    begin
        ctrl = '0;
        alumux1_sel = alu1_rs1;
        alumux2_sel = alu2_i_imm;
        cmpmux_sel = cmp_i_imm;
        known = 1'b1;

        case (instr.r.opcode)
            op_lui:
            begin
                ctrl.load_regfile = 1'b1;
                alumux2_sel = alu2_u_imm;
            end
            op_auipc:
            begin
                ctrl.load_regfile = 1'b1;
                alumux1_sel = alu1_pc;
                alumux2_sel = alu2_u_imm;
            end
            op_jal:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.is_jump = 1'b1;
                alumux1_sel = alu1_pc;
                alumux2_sel = alu2_j_imm;
            end
            op_jalr:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.is_jump = 1'b1;
            end
            op_br:
            begin
                ctrl.is_branch = 1'b1;
                ctrl.cmpop = branch_funct3'(instr.r.funct3);
                alumux1_sel = alu1_pc;
                alumux2_sel = alu2_b_imm;
                cmpmux_sel = cmp_rs2;
                if (is_slt)
                    known = 1'b0;
            end
            op_load:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read = 1'b1;
            end
            op_store:
            begin
                ctrl.mem_write = 1'b1;
                alumux2_sel = alu2_s_imm;
            end
            op_imm:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop = arith_op;
                if (is_slt)
                    ctrl.cmpop = instr.r.funct3[0] ? bltu : blt;
                if (instr.r.funct3 == 3'b001 && (alt_op || !shift_ok))
                    known = 1'b0;
                if (instr.r.funct3 == 3'b101 && !shift_ok)
                    known = 1'b0;
            end
            op_reg:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop = arith_op;
                alumux2_sel = alu2_rs2;
                cmpmux_sel = cmp_rs2;
                if (is_slt)
                    ctrl.cmpop = instr.r.funct3[0] ? bltu : blt;
                if ((instr.r.funct7 & 7'b1011111) != '0)
                    known = 1'b0;
                if (alt_op && instr.r.funct3 != 3'b000 && instr.r.funct3 != 3'b101)
                    known = 1'b0;
            end
            default:
            begin
                known = 1'b0;
            end
        endcase

        if (!known)
        begin
            ctrl = '0;
        end
        else
        begin
            ctrl.opcode = instr.r.opcode;
            ctrl.funct3 = instr.r.funct3;
            // writes to x0 are dropped here
            if (instr.r.rd == '0)
                ctrl.load_regfile = 1'b0;
            if (ctrl.load_regfile)
                ctrl.rd = instr.r.rd;
        end
    end

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import rv32i_types_pkg::*;
(
    input  rv32i_instr_u      instr,
    input  rv32i_control_word id_ex,
    output logic              bubble
);

    logic reads_rs1;
    logic reads_rs2;
    logic dep_rs1;
    logic dep_rs2;

    // which source fields are real operands
    always_comb
    begin
        case (instr.r.opcode)
            op_lui, op_auipc, op_jal:
            begin
                reads_rs1 = 1'b0;
                reads_rs2 = 1'b0;
            end
            op_reg, op_br, op_store:
            begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
            end
            default:
            begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b0;
            end
        endcase
    end

    assign dep_rs1 = reads_rs1 && (id_ex.rd == instr.r.rs1);
    assign dep_rs2 = reads_rs2 && (id_ex.rd == instr.r.rs2);

    // load in EX has no data until MEM
    assign bubble = id_ex.mem_read && (id_ex.rd != '0) && (dep_rs1 || dep_rs2);

endmodule

// File: hw/instruction_decode.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module instruction_decode
    import rv32i_types_pkg::*;
    import operand_sel_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  rv32i_word         pc,
    input  rv32i_word         instr,
    input  logic              ma_stall,
    input  logic              br_taken,
    input  rv32i_word         wb_data,
    input  rv32i_reg          wb_rd,
    input  logic              wb_load,
    output rv32i_control_word ctrl_out,
    output rv32i_word         instruction_out,
    output rv32i_word         pc_out,
    output rv32i_word         alu_in1_out,
    output rv32i_word         alu_in2_out,
    output rv32i_word         cmp_in_out,
    output rv32i_word         rs1_out,
    output rv32i_word         rs2_out,
    output logic              bubble
);

    rv32i_instr_u      instr_u;
    rv32i_word         i_imm;
    rv32i_word         s_imm;
    rv32i_word         b_imm;
    rv32i_word         u_imm;
    rv32i_word         j_imm;
    rv32i_word         reg_a;
    rv32i_word         reg_b;
    rv32i_word         alu_in1;
    rv32i_word         alu_in2;
    rv32i_word         cmp_in;
    rv32i_control_word ctrl;
    alumux1_sel_t      alumux1_sel;
    alumux2_sel_t      alumux2_sel;
    cmpmux_sel_t       cmpmux_sel;

    assign instr_u = instr;

    // sign extended immediates
    assign i_imm = {{20{instr_u.i.imm12[11]}}, instr_u.i.imm12};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    regfile regfile0 (
        .clk   (clk),
        .rst   (rst),
        .load  (wb_load),
        .in    (wb_data),
        .src_a (instr_u.r.rs1),
        .src_b (instr_u.r.rs2),
        .dest  (wb_rd),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    control_rom control_rom0 (
        .instr       (instr_u),
        .ctrl        (ctrl),
        .alumux1_sel (alumux1_sel),
        .alumux2_sel (alumux2_sel),
        .cmpmux_sel  (cmpmux_sel)
    );

    // compares against the registered load in EX
    hazard_unit hazard_unit0 (
        .instr  (instr_u),
        .id_ex  (ctrl_out),
        .bubble (bubble)
    );

    always_comb
    begin
        case (alumux1_sel)
            alu1_pc: alu_in1 = pc;
            default: alu_in1 = reg_a;
        endcase

        case (alumux2_sel)
            alu2_u_imm: alu_in2 = u_imm;
            alu2_b_imm: alu_in2 = b_imm;
            alu2_s_imm: alu_in2 = s_imm;
            alu2_j_imm: alu_in2 = j_imm;
            alu2_rs2:   alu_in2 = reg_b;
            default:    alu_in2 = i_imm;
        endcase

        case (cmpmux_sel)
            cmp_rs2: cmp_in = reg_b;
            default: cmp_in = i_imm;
        endcase
    end

    // ID/EX register; flush and bubble win over a memory stall
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl_out <= '0;
            instruction_out <= '0;
            pc_out <= '0;
            alu_in1_out <= '0;
            alu_in2_out <= '0;
            cmp_in_out <= '0;
            rs1_out <= '0;
            rs2_out <= '0;
        end
        else if (br_taken || bubble)
        begin
            ctrl_out <= '0;
            instruction_out <= `RV_NOP_INSTR;
            pc_out <= '0;
            alu_in1_out <= '0;
            alu_in2_out <= '0;
            cmp_in_out <= '0;
            rs1_out <= '0;
            rs2_out <= '0;
        end
        else if (!ma_stall)
        begin
            ctrl_out <= ctrl;
            instruction_out <= instr;
            pc_out <= pc;
            alu_in1_out <= alu_in1;
            alu_in2_out <= alu_in2;
            cmp_in_out <= cmp_in;
            rs1_out <= reg_a;
            rs2_out <= reg_b;
        end
    end

endmodule

// File: hw/operand_sel_pkg.sv
`include "rv32i_defines.svh"

package operand_sel_pkg;

    // first ALU operand
    typedef enum logic {
        alu1_rs1 = 1'b0,
        alu1_pc  = 1'b1
    } alumux1_sel_t;

    // second ALU operand
    typedef enum logic [2:0] {
        alu2_i_imm = 3'd0,
        alu2_u_imm = 3'd1,
        alu2_b_imm = 3'd2,
        alu2_s_imm = 3'd3,
        alu2_j_imm = 3'd4,
        alu2_rs2   = 3'd5
    } alumux2_sel_t;

    typedef enum logic {
        cmp_rs2   = 1'b0,
        cmp_i_imm = 1'b1
    } cmpmux_sel_t;

endpackage

// File: hw/regfile.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module regfile
    import rv32i_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  rv32i_word in,
    input  rv32i_reg  src_a,
    input  rv32i_reg  src_b,
    input  rv32i_reg  dest,
    output rv32i_word reg_a,
    output rv32i_word reg_b
);

    // x0 has no storage
    rv32i_word data [1:`RV_NUM_REGS-1];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < `RV_NUM_REGS; i++)
            begin
                data[i] <= '0;
            end
        end
        else if (load && dest != '0)
        begin
            data[dest] <= in;
        end
    end

    // writeback in flight is forwarded to decode
    always_comb
    begin
        if (src_a == '0)
            reg_a = '0;
        else if (load && dest == src_a)
            reg_a = in;
        else
            reg_a = data[src_a];

        if (src_b == '0)
            reg_b = '0;
        else if (load && dest == src_b)
            reg_b = in;
        else
            reg_b = data[src_b];
    end

endmodule

// File: hw/rv32i_types_pkg.sv
`include "rv32i_defines.svh"

package rv32i_types_pkg;

    typedef logic [`RV_XLEN-1:0] rv32i_word;
    typedef logic [`RV_REG_ADDR_W-1:0] rv32i_reg;

    // major opcodes of the base integer set
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    // same encoding as the branch funct3 field
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3;

    // all zero is a bubble
    typedef struct packed {
        rv32i_opcode  opcode;
        alu_ops       aluop;
        branch_funct3 cmpop;
        logic [2:0]   funct3;
        rv32i_reg     rd;
        logic         load_regfile;
        logic         mem_read;
        logic         mem_write;
        logic         is_branch;
        logic         is_jump;
    } rv32i_control_word;

    typedef struct packed {
        logic [6:0]  funct7;
        rv32i_reg    rs2;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        rv32i_opcode opcode;
    } rv32i_r_view;

    typedef struct packed {
        logic [11:0] imm12;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        rv32i_opcode opcode;
    } rv32i_i_view;

    typedef union packed {
        rv32i_r_view r;
        rv32i_i_view i;
    } rv32i_instr_u;

endpackage

// File: include/rv32i_defines.svh
`ifndef RV32I_DEFINES_SVH
`define RV32I_DEFINES_SVH

// datapath width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

// addi x0, x0, 0
`define RV_NOP_INSTR 32'h0000_0013

`endif

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f filelist.f \
    --top-module tb_instruction_decode \
    -Mdir obj_dir \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

// File: sim/tb_instruction_decode.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module tb_instruction_decode
    import rv32i_types_pkg::*;
;

    localparam int DRIVE_DELAY = 1;

    logic              clk;
    logic              rst;
    rv32i_word         pc;
    rv32i_word         instr;
    logic              ma_stall;
    logic              br_taken;
    rv32i_word         wb_data;
    rv32i_reg          wb_rd;
    logic              wb_load;
    rv32i_control_word ctrl_out;
    rv32i_word         instruction_out;
    rv32i_word         pc_out;
    rv32i_word         alu_in1_out;
    rv32i_word         alu_in2_out;
    rv32i_word         cmp_in_out;
    rv32i_word         rs1_out;
    rv32i_word         rs2_out;
    logic              bubble;

    logic [31:0] lfsr_state;
    rv32i_word   model_regs [0:`RV_NUM_REGS-1];

    instruction_decode dut0 (
        .clk             (clk),
        .rst             (rst),
        .pc              (pc),
        .instr           (instr),
        .ma_stall        (ma_stall),
        .br_taken        (br_taken),
        .wb_data         (wb_data),
        .wb_rd           (wb_rd),
        .wb_load         (wb_load),
        .ctrl_out        (ctrl_out),
        .instruction_out (instruction_out),
        .pc_out          (pc_out),
        .alu_in1_out     (alu_in1_out),
        .alu_in2_out     (alu_in2_out),
        .cmp_in_out      (cmp_in_out),
        .rs1_out         (rs1_out),
        .rs2_out         (rs2_out),
        .bubble          (bubble)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
            fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
                               name, actual, expected));
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int n = 0; n < count; n++)
        begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return value;
    endfunction

    // instruction encoders for the RV32I formats
    function automatic rv32i_word enc_r(input logic [6:0] f7, input rv32i_reg rs2,
                                        input rv32i_reg rs1, input logic [2:0] f3,
                                        input rv32i_reg rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic rv32i_word enc_i(input logic [11:0] imm, input rv32i_reg rs1,
                                        input logic [2:0] f3, input rv32i_reg rd,
                                        input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv32i_word enc_s(input logic [11:0] imm, input rv32i_reg rs2,
                                        input rv32i_reg rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_word enc_b(input logic [12:0] imm, input rv32i_reg rs2,
                                        input rv32i_reg rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv32i_word enc_u(input logic [19:0] imm, input rv32i_reg rd,
                                        input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv32i_word enc_j(input logic [20:0] imm, input rv32i_reg rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic rv32i_control_word ctrl_word(
        input rv32i_opcode op, input alu_ops aluop, input branch_funct3 cmpop,
        input logic [2:0] f3, input rv32i_reg rd, input logic writes_rd,
        input logic reads_mem, input logic writes_mem, input logic branch,
        input logic jump);
        rv32i_control_word c;
        c = '0;
        c.opcode = op;
        c.aluop = aluop;
        c.cmpop = cmpop;
        c.funct3 = f3;
        // x0 is never a destination
        c.load_regfile = writes_rd && (rd != '0);
        if (c.load_regfile)
            c.rd = rd;
        c.mem_read = reads_mem;
        c.mem_write = writes_mem;
        c.is_branch = branch;
        c.is_jump = jump;
        return c;
    endfunction

    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic issue(input rv32i_word ins, input rv32i_word p);
        instr = ins;
        pc = p;
        tick();
        check("instruction_out", instruction_out, ins);
        check("pc_out", pc_out, p);
    endtask

    task automatic check_all(input rv32i_control_word c, input rv32i_word ins,
                             input rv32i_word p, input rv32i_word a1, input rv32i_word a2,
                             input rv32i_word cmp, input rv32i_word r1, input rv32i_word r2);
        check("ctrl_out", 32'(ctrl_out), 32'(c));
        check("instruction_out", instruction_out, ins);
        check("pc_out", pc_out, p);
        check("alu_in1_out", alu_in1_out, a1);
        check("alu_in2_out", alu_in2_out, a2);
        check("cmp_in_out", cmp_in_out, cmp);
        check("rs1_out", rs1_out, r1);
        check("rs2_out", rs2_out, r2);
    endtask

    task automatic check_nop(input rv32i_word ins);
        check_all('0, ins, '0, '0, '0, '0, '0, '0);
    endtask

    task automatic wait_for_bubble(input int limit_ns);
        int waited;
        waited = 0;
        while (bubble !== 1'b1 && waited < limit_ns)
        begin
            #1;
            waited++;
        end
        if (bubble !== 1'b1)
            fail_run("bubble was not raised for a dependent instruction after a load");
    endtask

    // addi rd, x0, imm and its full expected ID/EX contents
    task automatic check_addi_x0(input rv32i_word ins, input rv32i_word p,
                                 input logic [11:0] imm, input rv32i_reg rd);
        rv32i_word sx;
        sx = {{20{imm[11]}}, imm};
        check_all(ctrl_word(op_imm, alu_add, beq, 3'b000, rd, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0),
                  ins, p, '0, sx, sx, '0, model_regs[imm[4:0]]);
    endtask

    task automatic test_reset();
        check_nop('0);
        check("bubble", 32'(bubble), 32'd0);
    endtask

    task automatic test_registers();
        rv32i_reg  rs1;
        rv32i_reg  rs2;
        rv32i_reg  rd;
        logic      sub;
        rv32i_word ins;
        wb_load = 1'b1;
        for (int r = 1; r < `RV_NUM_REGS; r++)
        begin
            wb_rd = rv32i_reg'(r);
            wb_data = take_bits(32);
            model_regs[r] = wb_data;
            tick();
        end
        // x0 stays zero
        wb_rd = '0;
        wb_data = take_bits(32);
        tick();
        wb_load = 1'b0;
        for (int k = 0; k < 10; k++)
        begin
            rs1 = (k == 0) ? rv32i_reg'(0) : rv32i_reg'(take_bits(5));
            rs2 = rv32i_reg'(take_bits(5));
            rd = rv32i_reg'(take_bits(5));
            sub = k[0];
            ins = enc_r(sub ? 7'h20 : 7'h00, rs2, rs1, 3'b000, rd, op_reg);
            issue(ins, take_bits(32) & 32'hffff_fffc);
            check("rs1_out", rs1_out, model_regs[rs1]);
            check("rs2_out", rs2_out, model_regs[rs2]);
            check("alu_in1_out", alu_in1_out, model_regs[rs1]);
            check("alu_in2_out", alu_in2_out, model_regs[rs2]);
            check("cmp_in_out", cmp_in_out, model_regs[rs2]);
            check("ctrl_out", 32'(ctrl_out), 32'(ctrl_word(op_reg, sub ? alu_sub : alu_add,
                  beq, 3'b000, rd, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0)));
        end
        // writeback to a source in the same cycle
        rs1 = rv32i_reg'(take_bits(5)) | 5'd1;
        rs2 = rv32i_reg'(take_bits(5));
        wb_load = 1'b1;
        wb_rd = rs1;
        wb_data = take_bits(32);
        model_regs[rs1] = wb_data;
        issue(enc_r(7'h00, rs2, rs1, 3'b000, 5'd7, op_reg), 32'h0000_1000);
        wb_load = 1'b0;
        check("rs1_out", rs1_out, model_regs[rs1]);
        check("rs2_out", rs2_out, model_regs[rs2]);
    endtask

    task automatic test_immediates();
        rv32i_reg    rs1;
        rv32i_reg    rs2;
        rv32i_reg    rd;
        logic [11:0] imm;
        logic [12:0] bimm;
        logic [19:0] uimm;
        logic [20:0] jimm;
        logic [2:0]  f3;
        rv32i_word   ins;
        rv32i_word   p;
        rv32i_word   sx;
        rs1 = rv32i_reg'(take_bits(5));
        rs2 = rv32i_reg'(take_bits(5));
        rd = rv32i_reg'(take_bits(5));
        imm = 12'(take_bits(12));
        sx = {{20{imm[11]}}, imm};
        p = take_bits(32) & 32'hffff_fffc;

        issue(enc_i(imm, rs1, 3'b000, rd, op_imm), p);
        check("alu_in1_out", alu_in1_out, model_regs[rs1]);
        check("alu_in2_out", alu_in2_out, sx);
        check("cmp_in_out", cmp_in_out, sx);
        check("ctrl_out", 32'(ctrl_out), 32'(ctrl_word(op_imm, alu_add, beq, 3'b000, rd,
              1'b1, 1'b0, 1'b0, 1'b0, 1'b0)));

        issue(enc_i(imm, rs1, 3'b010, rd, op_imm), p + 4);
        check("alu_in1_out", alu_in1_out, model_regs[rs1]);
        check("alu_in2_out", alu_in2_out, sx);
        check("cmp_in_out", cmp_in_out, sx);
        check("ctrl_out", 32'(ctrl_out), 32'(ctrl_word(op_imm, alu_add, blt, 3'b010, rd,
              1'b1, 1'b0, 1'b0, 1'b0, 1'b0)));

        uimm = 20'(take_bits(20));
        ins = enc_u(uimm, rd, op_lui);
        issue(ins, p + 8);
        check("alu_in2_out", alu_in2_out, {uimm, 12'h000});
        check("ctrl_out", 32'(ctrl_out), 32'(ctrl_word(op_lui, alu_add, beq, ins[14:12], rd,
              1'b1, 1'b0, 1'b0, 1'b0, 1'b0)));

        ins = enc_u(uimm, rd, op_auipc);
        issue(ins, p + 12);
        check("alu_in1_out", alu_in1_out, p + 12);
        check("alu_in2_out", alu_in2_out, {uimm, 12'h000});
        check("ctrl_out", 32'(ctrl_out), 32'(ctrl_word(op_auipc, alu_add, beq, ins[14:12], rd,
              1'b1, 1'b0, 1'b0, 1'b0, 1'b0)));

        jimm = {20'(take_bits(20)), 1'b0};
        ins = enc_j(jimm, rd);
        issue(ins, p + 16);
        check("alu_in1_out", alu_in1_out, p + 16);
        check("alu_in2_out", alu_in2_out, {{11{jimm[20]}}, jimm});
        check("ctrl_out", 32'(ctrl_out), 32'(ctrl_word(op_jal, alu_add, beq, ins[14:12], rd,
              1'b1, 1'b0, 1'b0, 1'b0, 1'b1)));

        // funct3 2 and 3 are not branches
        f3 = 3'(take_bits(3));
        if (f3[2:1] == 2'b01)
            f3[1] = 1'b0;
        bimm = {12'(take_bits(12)), 1'b0};
        issue(enc_b(bimm, rs2, rs1, f3), p + 20);
        check("alu_in1_out", alu_in1_out, p + 20);
        check("alu_in2_out", alu_in2_out, {{19{bimm[12]}}, bimm});
        check("cmp_in_out", cmp_in_out, model_regs[rs2]);
        check("ctrl_out", 32'(ctrl_out), 32'(ctrl_word(op_br, alu_add, branch_funct3'(f3), f3,
              '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0)));

        issue(enc_s(imm, rs2, rs1, 3'b010), p + 24);
        check("alu_in1_out", alu_in1_out, model_regs[rs1]);
        check("alu_in2_out", alu_in2_out, sx);
        check("rs2_out", rs2_out, model_regs[rs2]);
        check("ctrl_out", 32'(ctrl_out), 32'(ctrl_word(op_store, alu_add, beq, 3'b010, '0,
              1'b0, 1'b0, 1'b1, 1'b0, 1'b0)));

        issue(enc_i(imm, rs1, 3'b010, rd, op_load), p + 28);
        check("alu_in1_out", alu_in1_out, model_regs[rs1]);
        check("alu_in2_out", alu_in2_out, sx);
        check("cmp_in_out", cmp_in_out, sx);
        check("ctrl_out", 32'(ctrl_out), 32'(ctrl_word(op_load, alu_add, beq, 3'b010, rd,
              1'b1, 1'b1, 1'b0, 1'b0, 1'b0)));
        // nop reads only x0, so the load above cannot stall it
        issue(`RV_NOP_INSTR, p + 32);
    endtask

    task automatic test_stall();
        logic [11:0] imm_a;
        logic [11:0] imm_c;
        rv32i_word   ins_a;
        rv32i_word   ins_c;
        imm_a = 12'(take_bits(12));
        imm_c = 12'(take_bits(12));
        ins_a = enc_i(imm_a, 5'd0, 3'b000, 5'd9, op_imm);
        ins_c = enc_i(imm_c, 5'd0, 3'b000, 5'd10, op_imm);
        issue(ins_a, 32'h0000_2000);
        check_addi_x0(ins_a, 32'h0000_2000, imm_a, 5'd9);
        ma_stall = 1'b1;
        instr = enc_u(20'(take_bits(20)), 5'd11, op_lui);
        pc = 32'h0000_2004;
        tick();
        check_addi_x0(ins_a, 32'h0000_2000, imm_a, 5'd9);
        instr = ins_c;
        pc = 32'h0000_2008;
        tick();
        check_addi_x0(ins_a, 32'h0000_2000, imm_a, 5'd9);
        ma_stall = 1'b0;
        tick();
        check_addi_x0(ins_c, 32'h0000_2008, imm_c, 5'd10);
    endtask

    task automatic test_flush();
        br_taken = 1'b1;
        instr = enc_i(12'h123, 5'd3, 3'b000, 5'd4, op_imm);
        pc = 32'h0000_3000;
        tick();
        br_taken = 1'b0;
        check_nop(`RV_NOP_INSTR);
    endtask

    task automatic test_load_use();
        rv32i_word   add_ins;
        rv32i_word   lui_ins;
        logic [19:0] uimm;
        add_ins = enc_r(7'h00, 5'd2, 5'd5, 3'b000, 5'd6, op_reg);
        issue(enc_i(12'h000, 5'd1, 3'b010, 5'd5, op_load), 32'h0000_4000);
        instr = add_ins;
        pc = 32'h0000_4004;
        wait_for_bubble(20);
        tick();
        check_nop(`RV_NOP_INSTR);
        #2;
        check("bubble", 32'(bubble), 32'd0);
        tick();
        check("instruction_out", instruction_out, add_ins);
        check("rs1_out", rs1_out, model_regs[5]);
        check("rs2_out", rs2_out, model_regs[2]);

        // load into x0 carries no dependency
        issue(enc_i(12'h000, 5'd1, 3'b010, 5'd0, op_load), 32'h0000_4008);
        add_ins = enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd6, op_reg);
        instr = add_ins;
        pc = 32'h0000_400c;
        #2;
        check("bubble", 32'(bubble), 32'd0);
        tick();
        check("instruction_out", instruction_out, add_ins);

        // lui reads no register
        issue(enc_i(12'h000, 5'd1, 3'b010, 5'd5, op_load), 32'h0000_4010);
        uimm = 20'(take_bits(20));
        // rs1 and rs2 fields both name x5
        uimm[7:3] = 5'd5;
        uimm[12:8] = 5'd5;
        lui_ins = enc_u(uimm, 5'd5, op_lui);
        instr = lui_ins;
        pc = 32'h0000_4014;
        #2;
        check("bubble", 32'(bubble), 32'd0);
        tick();
        check("instruction_out", instruction_out, lui_ins);
    endtask

    initial
    begin
        lfsr_state = 32'h3622_3312;
        clk = 1'b0;
        rst = 1'b1;
        pc = '0;
        instr = `RV_NOP_INSTR;
        ma_stall = 1'b0;
        br_taken = 1'b0;
        wb_data = '0;
        wb_rd = '0;
        wb_load = 1'b0;
        for (int r = 0; r < `RV_NUM_REGS; r++)
        begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_reset();
        test_registers();
        test_immediates();
        test_stall();
        test_flush();
        test_load_use();

        $display("STATUS: PASS");
        $finish;
    end

endmodule
